/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= core_complex_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/core_complex_assertions.sv */
// Port checks for core_complex with tile i at cord i; fairness assumes under 8 cycles from timer to router.
`timescale 1ns/1ns
module core_complex_assertions
  #(parameter int num_tiles_p = 2)
  (input  logic                                 core_clk_i
   , input  logic                               rst_n_i
   , input  logic [num_tiles_p-1:0]             timer_irq_i
   , input  logic                               mem_cmd_v_o
   , input  logic [noc_pkg::flit_width_gp-1:0]  mem_cmd_o
   , input  logic                               mem_cmd_ready_and_i
   , input  logic                               mem_resp_v_i
   , input  logic [noc_pkg::flit_width_gp-1:0]  mem_resp_i
   , input  logic                               mem_resp_ready_and_o
   , input  logic [num_tiles_p-1:0]             resp_v_o
   , input  logic [num_tiles_p-1:0][31:0]       resp_data_o
  );

  int                            fail_count = 0;
  noc_pkg::mem_flit_u            cmd_view;
  noc_pkg::mem_flit_u            resp_view;
  logic [31:0]                   resp_data;
  logic                          cmd_fire;
  logic                          resp_hit;
  logic [num_tiles_p-1:0][8:0]   timer_dly_r;
  int                            old_edges [num_tiles_p];
  int                            xfers [num_tiles_p];
  int                            misses [num_tiles_p];

  assign cmd_view = mem_cmd_o;
  assign resp_view = mem_resp_i;
  assign resp_data = resp_view.resp.data;
  assign cmd_fire = mem_cmd_v_o & mem_cmd_ready_and_i;
  assign resp_hit = mem_resp_v_i & mem_resp_ready_and_o
                    & (resp_view.resp.opcode == noc_pkg::e_mem_resp)
                    & (int'(resp_view.resp.dst_cord) < num_tiles_p);

  // A trigger counts as waiting at the router once it is 8 cycles old.
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      timer_dly_r <= '0;
      for (int t = 0; t < num_tiles_p; t++)
      begin
        old_edges[t] <= 0;
        xfers[t] <= 0;
        misses[t] <= 0;
      end
    end
    else
    begin
      for (int t = 0; t < num_tiles_p; t++)
      begin
        timer_dly_r[t] <= {timer_dly_r[t][7:0], timer_irq_i[t]};
        if (timer_dly_r[t][7] && !timer_dly_r[t][8])
          old_edges[t] <= old_edges[t] + 1;
        if (cmd_fire && (int'(cmd_view.cmd.src_cord) == t))
          xfers[t] <= xfers[t] + 1;
        if (cmd_fire && ((int'(cmd_view.cmd.src_cord) == t) || (old_edges[t] <= xfers[t])))
          misses[t] <= 0;
        else if (cmd_fire)
          misses[t] <= misses[t] + 1;
      end
    end
  end

  reset_quiet: assert property (@(posedge core_clk_i)
    !rst_n_i |-> !mem_cmd_v_o && (resp_v_o == '0) && !mem_resp_ready_and_o)
    else begin fail_count++; $error("outputs active during reset"); end

  resp_ready_after_reset: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    rst_n_i |=> mem_resp_ready_and_o)
    else begin fail_count++; $error("mem_resp_ready_and_o low after reset release"); end

  cmd_hold: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_and_i |=> mem_cmd_v_o && $stable(mem_cmd_o))
    else begin fail_count++; $error("mem_cmd_o changed under back-pressure"); end

  // A dropped response must leave every tile quiet.
  resp_dropped: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    !resp_hit |-> ##2 (resp_v_o == '0))
    else begin fail_count++; $error("resp_v_o raised with no response routed"); end

  for (genvar t = 0; t < num_tiles_p; t++)
  begin : tile
    resp_delivered: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      resp_hit && (int'(resp_view.resp.dst_cord) == t)
      |-> ##2 resp_v_o[t] && (resp_data_o[t] == $past(resp_data, 2)))
      else begin fail_count++; $error("response to tile %0d late or wrong", t); end

    fair_grant: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      misses[t] <= num_tiles_p)
      else begin fail_count++; $error("tile %0d skipped too often", t); end
  end

endmodule

bind core_complex core_complex_assertions
  #(.num_tiles_p(num_tiles_p))
  checks
  (.core_clk_i(core_clk_i)
   ,.rst_n_i(rst_n_i)
   ,.timer_irq_i(timer_irq_i)
   ,.mem_cmd_v_o(mem_cmd_v_o)
   ,.mem_cmd_o(mem_cmd_o)
   ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
   ,.mem_resp_v_i(mem_resp_v_i)
   ,.mem_resp_i(mem_resp_i)
   ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
   ,.resp_v_o(resp_v_o)
   ,.resp_data_o(resp_data_o)
   );

/* bench/core_complex_tb.sv */
// Two tiles with random timer pulses; memory answers loads in order with data equal to address plus 1.
`timescale 1ns/1ns
module core_complex_tb;

  localparam int num_tiles_lp = 2;
  localparam int pulses_per_tile_lp = 12;
  localparam int max_cycles_lp = 40 * pulses_per_tile_lp * num_tiles_lp + 200;
  localparam logic [31:0] tile_stride_lp = 32'h0001_0000;
  localparam logic [noc_pkg::cord_width_gp-1:0] stray_cord_lp = 6'd5;

  logic                                 core_clk;
  logic                                 rst_n;
  logic [num_tiles_lp-1:0]              timer_irq;
  logic [num_tiles_lp-1:0]              soft_irq;
  logic [num_tiles_lp-1:0]              external_irq;
  logic                                 mem_cmd_v;
  logic [noc_pkg::flit_width_gp-1:0]    mem_cmd;
  logic                                 mem_cmd_ready_and;
  logic                                 mem_resp_v;
  logic [noc_pkg::flit_width_gp-1:0]    mem_resp;
  logic                                 mem_resp_ready_and;
  logic [num_tiles_lp-1:0]              resp_v;
  logic [num_tiles_lp-1:0][31:0]        resp_data;

  int                                   cycle_count;
  int                                   pulses_sent [num_tiles_lp];
  int                                   cmds_seen [num_tiles_lp];
  logic [noc_pkg::flit_width_gp-1:0]    mem_q [$];
  int                                   due_q [$];
  int                                   exp_tile_q [$];
  logic [31:0]                          exp_data_q [$];
  logic                                 stray_sent;
  logic                                 running;

  core_complex
    #(.num_tiles_p(num_tiles_lp))
    core_complex_inst
    (.core_clk_i(core_clk)
     ,.rst_n_i(rst_n)
     ,.timer_irq_i(timer_irq)
     ,.soft_irq_i(soft_irq)
     ,.external_irq_i(external_irq)
     ,.mem_cmd_v_o(mem_cmd_v)
     ,.mem_cmd_o(mem_cmd)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and)
     ,.mem_resp_v_i(mem_resp_v)
     ,.mem_resp_i(mem_resp)
     ,.mem_resp_ready_and_o(mem_resp_ready_and)
     ,.resp_v_o(resp_v)
     ,.resp_data_o(resp_data)
     );

  always #2 core_clk = ~core_clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input logic [39:0] expected,
                             input logic [39:0] actual);
    if (expected !== actual)
      report_failure($sformatf("CHECK FAILED %s expected %0h actual %0h",
                               test_name, expected, actual));
  endtask

  function automatic logic all_done();
    logic done;
    done = stray_sent && (mem_q.size() == 0) && (exp_tile_q.size() == 0);
    for (int t = 0; t < num_tiles_lp; t++)
      done = done && (pulses_sent[t] == pulses_per_tile_lp) && (cmds_seen[t] == pulses_sent[t]);
    return done;
  endfunction

  initial
  begin
    void'($urandom(85888));
    core_clk = 1'b0;
    rst_n = 1'b0;
    timer_irq = '0;
    soft_irq = '0;
    external_irq = '0;
    mem_cmd_ready_and = 1'b0;
    mem_resp_v = 1'b0;
    mem_resp = '0;
    cycle_count = 0;
    stray_sent = 1'b0;
    running = 1'b0;
    for (int t = 0; t < num_tiles_lp; t++)
    begin
      pulses_sent[t] = 0;
      cmds_seen[t] = 0;
    end
    repeat (2) @(posedge core_clk);
    rst_n <= 1'b1;
    running <= 1'b1;
    while (!all_done())
      @(negedge core_clk);
    if (core_complex_inst.checks.fail_count == 0)
    begin
      $display("TEST OK");
      $finish;
    end
    else
      report_failure("a concurrent assertion on the DUT ports failed");
  end

  // One-cycle timer pulses keep a low cycle between triggers.
  always @(posedge core_clk)
  begin
    if (running)
    begin
      mem_cmd_ready_and <= ($urandom_range(0, 2) != 0);
      soft_irq <= num_tiles_lp'($urandom_range(0, 3));
      external_irq <= num_tiles_lp'($urandom_range(0, 3));
      for (int t = 0; t < num_tiles_lp; t++)
      begin
        if (timer_irq[t])
          timer_irq[t] <= 1'b0;
        else if ((pulses_sent[t] < pulses_per_tile_lp) && ($urandom_range(0, 3) == 0))
        begin
          timer_irq[t] <= 1'b1;
          pulses_sent[t] <= pulses_sent[t] + 1;
        end
      end
    end
  end

  // Memory model accepts a command and queues its answer.
  always @(posedge core_clk)
  begin
    noc_pkg::mem_flit_u cmd;
    noc_pkg::mem_flit_u rsp;
    int src;
    logic [31:0] exp_addr;
    if (rst_n && mem_cmd_v && mem_cmd_ready_and)
    begin
      cmd = mem_cmd;
      src = int'(cmd.cmd.src_cord);
      if (src >= num_tiles_lp)
        report_failure($sformatf("command carries unknown source cord %0d", src));
      else if (cmds_seen[src] >= pulses_sent[src])
        report_failure($sformatf("tile %0d issued a command without a timer pulse", src));
      else
      begin
        exp_addr = tile_stride_lp * 32'(src) + 32'(4 * cmds_seen[src]);
        check_value("command opcode", 40'(noc_pkg::e_mem_load), 40'(cmd.cmd.opcode));
        check_value($sformatf("load address tile %0d", src), 40'(exp_addr), 40'(cmd.cmd.addr));
        cmds_seen[src] = cmds_seen[src] + 1;
        rsp.resp.opcode = noc_pkg::e_mem_resp;
        rsp.resp.dst_cord = cmd.cmd.src_cord;
        rsp.resp.data = cmd.cmd.addr + 32'd1;
        mem_q.push_back(rsp);
        due_q.push_back(cycle_count + int'($urandom_range(1, 6)));
      end
    end
  end

  // Answers leave in order once due; one answer goes to a cord with no tile.
  always @(posedge core_clk)
  begin
    noc_pkg::mem_flit_u rsp;
    mem_resp_v <= 1'b0;
    if (running && mem_resp_ready_and)
    begin
      if (!stray_sent && (cycle_count >= 60))
      begin
        rsp.resp.opcode = noc_pkg::e_mem_resp;
        rsp.resp.dst_cord = stray_cord_lp;
        rsp.resp.data = 32'hbad0_0001;
        mem_resp_v <= 1'b1;
        mem_resp <= rsp;
        stray_sent <= 1'b1;
      end
      else if ((mem_q.size() != 0) && (due_q[0] <= cycle_count))
      begin
        rsp = mem_q.pop_front();
        void'(due_q.pop_front());
        mem_resp_v <= 1'b1;
        mem_resp <= rsp;
        exp_tile_q.push_back(int'(rsp.resp.dst_cord));
        exp_data_q.push_back(rsp.resp.data);
      end
    end
  end

  always @(posedge core_clk)
  begin
    int tile;
    logic [31:0] data;
    if (rst_n && (resp_v != '0))
    begin
      if (exp_tile_q.size() == 0)
        report_failure("a tile presented response data with no response outstanding");
      else
      begin
        tile = exp_tile_q.pop_front();
        data = exp_data_q.pop_front();
        check_value("response strobe", 40'(num_tiles_lp'(1) << tile), 40'(resp_v));
        check_value($sformatf("response data tile %0d", tile), 40'(data), 40'(resp_data[tile]));
      end
    end
  end

  // Lost commands leave the count short when the run runs out of cycles.
  always @(posedge core_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles_lp)
    begin
      for (int t = 0; t < num_tiles_lp; t++)
        check_value($sformatf("command count tile %0d", t), 40'(pulses_sent[t]),
                    40'(cmds_seen[t]));
      report_failure($sformatf("run stopped after %0d cycles with work still outstanding",
                               cycle_count));
    end
    else if (core_complex_inst.checks.fail_count != 0)
      report_failure("a concurrent assertion on the DUT ports failed");
  end

endmodule

/* compile.f */
rtl/noc_pkg.sv
rtl/mem_link_if.sv
rtl/tile_cmd_issuer.sv
rtl/link_fifo.sv
rtl/mem_edge_router.sv
rtl/core_complex.sv
bench/core_complex_assertions.sv
bench/core_complex_tb.sv

/* rtl/core_complex.sv */
// Tile i owns cord i and issues loads only; num_tiles_p from 1 to 8, one memory port at the south edge.
`timescale 1ns/1ns
module core_complex
  #(parameter int num_tiles_p = 2
    , parameter int fifo_els_p = 2
    , parameter int irq_stages_p = 2)
  (input  logic                                 core_clk_i
   , input  logic                               rst_n_i

   , input  logic [num_tiles_p-1:0]             timer_irq_i
   , input  logic [num_tiles_p-1:0]             soft_irq_i
   , input  logic [num_tiles_p-1:0]             external_irq_i

   , output logic                               mem_cmd_v_o
   , output logic [noc_pkg::flit_width_gp-1:0]  mem_cmd_o
   , input  logic                               mem_cmd_ready_and_i

   , input  logic                               mem_resp_v_i
   , input  logic [noc_pkg::flit_width_gp-1:0]  mem_resp_i
   , output logic                               mem_resp_ready_and_o

   , output logic [num_tiles_p-1:0]             resp_v_o
   , output logic [num_tiles_p-1:0][31:0]       resp_data_o
  );

  logic [num_tiles_p-1:0]  resp_strobe;
  noc_pkg::mem_flit_u      resp_word;

  mem_link_if tile_link [num_tiles_p] ();
  mem_link_if edge_link [num_tiles_p] ();

  for (genvar i = 0; i < num_tiles_p; i++)
  begin : tile
    localparam logic [noc_pkg::cord_width_gp-1:0] tile_cord_lp = i;

    tile_cmd_issuer
      #(.irq_stages_p(irq_stages_p))
      issuer
      (.core_clk_i(core_clk_i)
       ,.rst_n_i(rst_n_i)
       ,.timer_irq_i(timer_irq_i[i])
       ,.soft_irq_i(soft_irq_i[i])
       ,.external_irq_i(external_irq_i[i])
       ,.tile_id_i(tile_cord_lp)
       ,.resp_strobe_i(resp_strobe[i])
       ,.resp_word_i(resp_word)
       ,.link(tile_link[i])
       ,.resp_v_o(resp_v_o[i])
       ,.resp_data_o(resp_data_o[i])
       );

    link_fifo
      #(.fifo_els_p(fifo_els_p))
      fifo
      (.core_clk_i(core_clk_i)
       ,.rst_n_i(rst_n_i)
       ,.enq(tile_link[i])
       ,.deq(edge_link[i])
       );
  end

  mem_edge_router
    #(.num_tiles_p(num_tiles_p))
    router
    (.core_clk_i(core_clk_i)
     ,.rst_n_i(rst_n_i)
     ,.tile_links(edge_link)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
     ,.resp_strobe_o(resp_strobe)
     ,.resp_word_o(resp_word)
     );

endmodule

/* rtl/link_fifo.sv */
// Needs fifo_els_p of 2 or more; no bypass, so a word takes one cycle to come out.
`timescale 1ns/1ns
module link_fifo
  #(parameter int fifo_els_p = 2)
  (input  logic      core_clk_i
   , input  logic    rst_n_i

   , mem_link_if.rx  enq
   , mem_link_if.tx  deq
  );

  localparam int ptr_width_lp = $clog2(fifo_els_p);
  localparam int cnt_width_lp = $clog2(fifo_els_p + 1);

  noc_pkg::mem_flit_u        flit_mem_r [fifo_els_p];
  logic [1:0]                irq_mem_r  [fifo_els_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [cnt_width_lp-1:0]   count_r;
  logic                      full;
  logic                      empty;
  logic                      enq_fire;
  logic                      deq_fire;

  assign full = (count_r == cnt_width_lp'(fifo_els_p));
  assign empty = (count_r == '0);
  assign enq_fire = enq.v & ~full;
  assign deq_fire = deq.ready_and & ~empty;

  assign enq.ready_and = ~full;
  assign deq.v = ~empty;
  assign deq.flit = flit_mem_r[rd_ptr_r];
  assign deq.irq_status = irq_mem_r[rd_ptr_r];

  always_ff @(posedge core_clk_i)
  begin
    if (enq_fire)
    begin
      flit_mem_r[wr_ptr_r] <= enq.flit;
      irq_mem_r[wr_ptr_r] <= enq.irq_status;
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end
    else
    begin
      if (enq_fire)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;

      if (deq_fire)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;

      if (enq_fire && !deq_fire)
        count_r <= count_r + 1'b1;
      else if (deq_fire && !enq_fire)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

/* rtl/mem_edge_router.sv */
// Responses are never back-pressured; one with an unknown cord or a non-response opcode is dropped.
`timescale 1ns/1ns
module mem_edge_router
  #(parameter int num_tiles_p = 2)
  (input  logic                                 core_clk_i
   , input  logic                               rst_n_i

   , mem_link_if.rx                             tile_links [num_tiles_p]

   , output logic                               mem_cmd_v_o
   , output logic [noc_pkg::flit_width_gp-1:0]  mem_cmd_o
   , input  logic                               mem_cmd_ready_and_i

   , input  logic                               mem_resp_v_i
   , input  logic [noc_pkg::flit_width_gp-1:0]  mem_resp_i
   , output logic                               mem_resp_ready_and_o

   , output logic [num_tiles_p-1:0]             resp_strobe_o
   , output noc_pkg::mem_flit_u                 resp_word_o
  );

  localparam int idx_width_lp = (num_tiles_p > 1) ? $clog2(num_tiles_p) : 1;

  logic [num_tiles_p-1:0]    tile_v;
  noc_pkg::mem_flit_u        tile_flit [num_tiles_p];
  logic [idx_width_lp-1:0]   last_r;
  logic [idx_width_lp-1:0]   win_idx;
  logic                      win_v;
  logic                      load_en;
  logic                      cmd_v_r;
  noc_pkg::mem_flit_u        cmd_r;
  noc_pkg::mem_flit_u        resp_in;
  logic                      resp_ready_r;
  logic                      resp_hit;
  logic [num_tiles_p-1:0]    resp_strobe_r;
  noc_pkg::mem_flit_u        resp_word_r;

  for (genvar i = 0; i < num_tiles_p; i++)
  begin : link
    assign tile_v[i] = tile_links[i].v;
    assign tile_flit[i] = tile_links[i].flit;
    assign tile_links[i].ready_and = load_en & win_v & (win_idx == idx_width_lp'(i));
  end

  // Search starts just past the last winner.
  always_comb
  begin
    int idx;
    win_v = 1'b0;
    win_idx = last_r;
    for (int off = 1; off <= num_tiles_p; off++)
    begin
      idx = int'(last_r) + off;
      if (idx >= num_tiles_p)
        idx = idx - num_tiles_p;
      if (!win_v && tile_v[idx])
      begin
        win_v = 1'b1;
        win_idx = idx_width_lp'(idx);
      end
    end
  end

  // Output register refills when empty or draining.
  assign load_en = ~cmd_v_r | mem_cmd_ready_and_i;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cmd_v_r <= 1'b0;
      last_r <= idx_width_lp'(num_tiles_p - 1);
    end
    else if (load_en)
    begin
      cmd_v_r <= win_v;
      if (win_v)
        last_r <= win_idx;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (load_en && win_v)
      cmd_r <= tile_flit[win_idx];
  end

  assign mem_cmd_v_o = cmd_v_r;
  assign mem_cmd_o = cmd_r;

  assign resp_in = mem_resp_i;
  assign resp_hit = mem_resp_v_i & resp_ready_r
                    & (resp_in.resp.opcode == noc_pkg::e_mem_resp)
                    & noc_pkg::cord_is_tile(resp_in.resp.dst_cord, num_tiles_p);

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_ready_r <= 1'b0;
      resp_strobe_r <= '0;
    end
    else
    begin
      resp_ready_r <= 1'b1;
      resp_strobe_r <= resp_hit ? (num_tiles_p'(1) << resp_in.resp.dst_cord) : '0;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (resp_hit)
      resp_word_r <= resp_in;
  end

  assign mem_resp_ready_and_o = resp_ready_r;
  assign resp_strobe_o = resp_strobe_r;
  assign resp_word_o = resp_word_r;

endmodule

/* rtl/mem_link_if.sv */
// Ready-and handshake; a sender holds flit and irq_status while v is high and ready_and is low.
`timescale 1ns/1ns
interface mem_link_if;

  logic                v;
  logic                ready_and;
  noc_pkg::mem_flit_u  flit;
  // Soft in bit 1, external in bit 0.
  logic [1:0]          irq_status;

  modport tx
  (
    output v,
    output flit,
    output irq_status,
    input  ready_and
  );

  modport rx
  (
    input  v,
    input  flit,
    input  irq_status,
    output ready_and
  );

endinterface

/* rtl/noc_pkg.sv */
// Cord and address widths fix the 40-bit flit; tile windows are 64 KiB apart starting at zero.
package noc_pkg;

  parameter int cord_width_gp = 6;
  parameter int addr_width_gp = 32;
  parameter int flit_width_gp = 2 + cord_width_gp + addr_width_gp;

  parameter logic [addr_width_gp-1:0] tile_addr_base_gp = 32'h0001_0000;

  typedef enum logic [1:0]
  {
    e_mem_load = 2'b00,
    e_mem_resp = 2'b01,
    e_mem_nop  = 2'b11
  } mem_opcode_e;

  typedef struct packed
  {
    mem_opcode_e              opcode;
    logic [cord_width_gp-1:0] src_cord;
    logic [addr_width_gp-1:0] addr;
  } mem_cmd_s;

  typedef struct packed
  {
    mem_opcode_e              opcode;
    logic [cord_width_gp-1:0] dst_cord;
    logic [31:0]              data;
  } mem_resp_s;

  // Commands travel south, responses north, on the same word.
  typedef union packed
  {
    mem_cmd_s  cmd;
    mem_resp_s resp;
  } mem_flit_u;

  function automatic logic [addr_width_gp-1:0] tile_base_addr
    (input logic [cord_width_gp-1:0] cord);
    return {{(addr_width_gp-cord_width_gp){1'b0}}, cord} * tile_addr_base_gp;
  endfunction

  function automatic logic cord_is_tile
    (input logic [cord_width_gp-1:0] cord, input int num_tiles);
    return int'(cord) < num_tiles;
  endfunction

endpackage

/* rtl/tile_cmd_issuer.sv */
// Pending loads saturate at 255; after 2^14 loads the address runs into the next tile's window.
`timescale 1ns/1ns
module tile_cmd_issuer
  #(parameter int irq_stages_p = 2)
  (input  logic                              core_clk_i
   , input  logic                            rst_n_i

   , input  logic                            timer_irq_i
   , input  logic                            soft_irq_i
   , input  logic                            external_irq_i

   , input  logic [noc_pkg::cord_width_gp-1:0] tile_id_i

   , input  logic                            resp_strobe_i
   , input  noc_pkg::mem_flit_u              resp_word_i

   , mem_link_if.tx                          link

   , output logic                            resp_v_o
   , output logic [31:0]                     resp_data_o
  );

  localparam int pend_width_lp = 8;

  logic [irq_stages_p-1:0][2:0]         irq_pipe_r;
  logic [2:0]                           irq_sync;
  logic                                 timer_last_r;
  logic                                 timer_rise;
  logic [pend_width_lp-1:0]             pending_r;
  logic [noc_pkg::addr_width_gp-3:0]    seq_r;
  logic                                 xfer;
  logic [1:0]                           status_r;
  noc_pkg::mem_flit_u                   cmd_flit;

  // Timer, soft, external from high bit to low.
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      irq_pipe_r <= '0;
      timer_last_r <= 1'b0;
    end
    else
    begin
      irq_pipe_r[0] <= {timer_irq_i, soft_irq_i, external_irq_i};
      for (int s = 1; s < irq_stages_p; s++)
      begin
        irq_pipe_r[s] <= irq_pipe_r[s-1];
      end
      timer_last_r <= irq_sync[2];
    end
  end

  assign irq_sync = irq_pipe_r[irq_stages_p-1];
  assign timer_rise = irq_sync[2] & ~timer_last_r;
  assign xfer = link.v & link.ready_and;

  // A trigger and a transfer in the same cycle cancel.
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pending_r <= '0;
      seq_r <= '0;
    end
    else
    begin
      if (timer_rise && !xfer && (pending_r != '1))
        pending_r <= pending_r + 1'b1;
      else if (xfer && !timer_rise)
        pending_r <= pending_r - 1'b1;

      if (xfer)
        seq_r <= seq_r + 1'b1;
    end
  end

  // Frozen while a command is stalled.
  always_ff @(posedge core_clk_i)
  begin
    if (!(link.v && !link.ready_and))
      status_r <= irq_sync[1:0];
  end

  always_comb
  begin
    cmd_flit.cmd.opcode = (pending_r != '0) ? noc_pkg::e_mem_load : noc_pkg::e_mem_nop;
    cmd_flit.cmd.src_cord = tile_id_i;
    cmd_flit.cmd.addr = noc_pkg::tile_base_addr(tile_id_i) + {seq_r, 2'b00};
  end

  assign link.v = (pending_r != '0);
  assign link.flit = cmd_flit;
  assign link.irq_status = status_r;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else
      resp_v_o <= resp_strobe_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (resp_strobe_i)
      resp_data_o <= resp_word_i.resp.data;
  end

endmodule
